// ==== src/cam_pkg.sv ====
// Shared widths, register map and enums; register offsets assume word-aligned 5-bit AXI addresses
`default_nettype none

package cam_pkg;

  // ====================
  // Datapath widths
  localparam int pix_w   = 12;  // Raw sensor sample
  localparam int coord_w = 12;  // Column and row counts
  localparam int out_w   = 16;  // Packed output word

  // ====================
  // AXI4-Lite bus
  localparam int axi_addr_w = 5;
  localparam int axi_data_w = 32;

  // Register offsets
  localparam logic [axi_addr_w-1:0] reg_ctrl   = 5'h00;  // Start and mode
  localparam logic [axi_addr_w-1:0] reg_width  = 5'h04;  // Crop width in samples
  localparam logic [axi_addr_w-1:0] reg_height = 5'h08;  // Crop height in lines
  localparam logic [axi_addr_w-1:0] reg_thresh = 5'h0C;  // Green threshold
  localparam logic [axi_addr_w-1:0] reg_frames = 5'h10;  // Frame count, read only

  // Response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Control register bits
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_mode_bit  = 1;

  // Register reset values
  localparam logic [coord_w-1:0] rst_width  = 12'd1280;
  localparam logic [coord_w-1:0] rst_height = 12'd960;
  localparam logic [pix_w-1:0]   rst_thresh = 12'd2048;  // Mid scale

  // Output word format, control bit 1
  typedef enum logic {
    mode_rgb555 = 1'b0,
    mode_binary = 1'b1
  } out_mode_e;

  // Write channel FSM
  typedef enum logic {
    wr_idle,  // Waiting for address and data together
    wr_resp   // Holding bvalid until bready
  } wr_state_e;

endpackage

`default_nettype wire

// ==== src/cam_ifs.sv ====
// Stream has no ready signal so every sink must take each valid beat in the cycle it appears
`default_nettype none
`timescale 1ns/1ps

// ====================
// Pixel stream between stages
interface pix_if import cam_pkg::*; #(
  parameter int data_w = pix_w  // Payload bits per beat
) ();

  logic               valid;      // One pixel this cycle
  logic [data_w-1:0]  data;       // Sample or packed colour
  logic [coord_w-1:0] x;          // Column of this beat
  logic [coord_w-1:0] y;          // Row of this beat
  logic               frame_end;  // Single pulse after last line of a gated frame

  // Producing stage
  modport source (
    output valid, data, x, y, frame_end
  );

  // Consuming stage
  modport sink (
    input valid, data, x, y, frame_end
  );

  // Frame counting only
  modport monitor (
    input frame_end
  );

endinterface

// ====================
// Settings from the register block
interface cam_cfg_if import cam_pkg::*; ();

  logic [coord_w-1:0] width;       // Crop width
  logic [coord_w-1:0] height;      // Crop height
  logic               capture_en;  // Start bit
  out_mode_e          mode;        // Output word format
  logic [pix_w-1:0]   threshold;   // Binary mask level

  modport ctrl (
    output width, height, capture_en, mode, threshold
  );

  modport capture (
    input width, height, capture_en
  );

  modport format (
    input mode, threshold
  );

endinterface

`default_nettype wire

// ==== src/camera_ctrl.sv ====
// Single outstanding write and read; width writes clamp to max_width, height is not clamped
`default_nettype none
`timescale 1ns/1ps

module camera_ctrl import cam_pkg::*; #(
  parameter int max_width = 1280  // Line buffer depth downstream
) (
  input  logic                    ccd_pixel_clk,
  input  logic                    rst,
  // Write address and data
  input  logic [axi_addr_w-1:0]   awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [axi_data_w-1:0]   wdata,
  input  logic [axi_data_w/8-1:0] wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  // Write response
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  // Read address and data
  input  logic [axi_addr_w-1:0]   araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [axi_data_w-1:0]   rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  cam_cfg_if.ctrl                 cfg,
  pix_if.monitor                  mon
);

  localparam logic [coord_w-1:0] max_w_c = coord_w'(max_width);

  wr_state_e             wr_state;
  logic                  wr_fire;     // Address and data taken this cycle
  logic                  rd_fire;
  logic                  wr_ok;       // Writable offset
  logic                  rd_ok;       // Readable offset
  logic [axi_data_w-1:0] wmask;       // Byte strobes widened to bits
  logic [axi_data_w-1:0] wr_cur;      // Register being written, as read
  logic [axi_data_w-1:0] wr_val;      // Merged write value
  logic [axi_data_w-1:0] rd_val;
  logic [axi_data_w-1:0] ctrl_word;
  logic                  ctrl_start;
  out_mode_e             ctrl_mode;
  logic [coord_w-1:0]    width_q;
  logic [coord_w-1:0]    height_q;
  logic [pix_w-1:0]      thresh_q;
  logic [axi_data_w-1:0] frame_cnt;   // Gated frames since reset

  // ====================
  // Handshake
  assign awready = (wr_state == wr_idle) && awvalid && wvalid;  // Both pulse together
  assign wready  = awready;
  assign wr_fire = awready;
  assign bvalid  = (wr_state == wr_resp);
  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;

  assign ctrl_word = {{(axi_data_w-2){1'b0}}, ctrl_mode, ctrl_start};

  // Write decode and strobe merge
  always_comb begin
    for (int i = 0; i < axi_data_w / 8; i++) begin
      wmask[8*i +: 8] = {8{wstrb[i]}};
    end
    wr_ok = 1'b1;
    case (awaddr)
      reg_ctrl:   wr_cur = ctrl_word;
      reg_width:  wr_cur = axi_data_w'(width_q);
      reg_height: wr_cur = axi_data_w'(height_q);
      reg_thresh: wr_cur = axi_data_w'(thresh_q);
      default: begin  // Unmapped or frame count
        wr_cur = '0;
        wr_ok  = 1'b0;
      end
    endcase
    wr_val = (wr_cur & ~wmask) | (wdata & wmask);
  end

  // Read decode
  always_comb begin
    rd_ok = 1'b1;
    case (araddr)
      reg_ctrl:   rd_val = ctrl_word;
      reg_width:  rd_val = axi_data_w'(width_q);
      reg_height: rd_val = axi_data_w'(height_q);
      reg_thresh: rd_val = axi_data_w'(thresh_q);
      reg_frames: rd_val = frame_cnt;
      default: begin
        rd_val = '0;  // SLVERR reads return zero
        rd_ok  = 1'b0;
      end
    endcase
  end

  // ====================
  // Write FSM, register file and frame counter
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      wr_state   <= wr_idle;
      ctrl_start <= 1'b0;
      ctrl_mode  <= mode_rgb555;
      width_q    <= rst_width;
      height_q   <= rst_height;
      thresh_q   <= rst_thresh;
      frame_cnt  <= '0;
    end else begin
      case (wr_state)
        wr_idle: if (wr_fire) wr_state <= wr_resp;
        wr_resp: if (bready)  wr_state <= wr_idle;  // Next write waits a cycle
        default: wr_state <= wr_idle;
      endcase
      if (wr_fire && wr_ok) begin
        case (awaddr)
          reg_ctrl: begin
            ctrl_start <= wr_val[ctrl_start_bit];
            ctrl_mode  <= out_mode_e'(wr_val[ctrl_mode_bit]);
          end
          reg_width:  width_q  <= (wr_val > axi_data_w'(max_width)) ? max_w_c
                                                                      : wr_val[coord_w-1:0];
          reg_height: height_q <= wr_val[coord_w-1:0];
          reg_thresh: thresh_q <= wr_val[pix_w-1:0];
          default: ;
        endcase
      end
      if (mon.frame_end) frame_cnt <= frame_cnt + 1'b1;
    end
  end

  // Response payload
  always_ff @(posedge ccd_pixel_clk) begin
    if (wr_fire) bresp <= wr_ok ? resp_okay : resp_slverr;
    if (rd_fire) begin
      rdata <= rd_val;
      rresp <= rd_ok ? resp_okay : resp_slverr;
    end
  end

  // Read valid held until rready
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) rvalid <= 1'b0;
    else if (rd_fire) rvalid <= 1'b1;
    else if (rready) rvalid <= 1'b0;
  end

  // ====================
  // Settings out
  assign cfg.width      = width_q;
  assign cfg.height     = height_q;
  assign cfg.capture_en = ctrl_start;  // Applied at next frame start
  assign cfg.mode       = ctrl_mode;
  assign cfg.threshold  = thresh_q;

endmodule

`default_nettype wire

// ==== src/ccd_capture.sv ====
// Counters saturate at 4095 so sensor lines and frames beyond that stay outside any crop
`default_nettype none
`timescale 1ns/1ps

module ccd_capture import cam_pkg::*; (
  input  logic             ccd_pixel_clk,
  input  logic             rst,
  input  logic [pix_w-1:0] ccd_data,
  input  logic             ccd_fval,
  input  logic             ccd_lval,
  cam_cfg_if.capture       cfg,
  pix_if.source            raw
);

  logic [pix_w-1:0]   data_q;
  logic               fval_q;
  logic               lval_q;
  logic               fval_d;  // Previous strobes for edges
  logic               lval_d;
  logic [coord_w-1:0] col;
  logic [coord_w-1:0] row;
  logic               gate;
  logic               fval_rise;
  logic               fval_fall;
  logic               lval_fall;
  logic               gate_open;
  logic               in_crop;

  // ====================
  // Pin registers
  always_ff @(posedge ccd_pixel_clk) begin
    data_q <= ccd_data;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      fval_q <= 1'b0;
      lval_q <= 1'b0;
      fval_d <= 1'b0;
      lval_d <= 1'b0;
    end else begin
      fval_q <= ccd_fval;
      lval_q <= ccd_lval;
      fval_d <= fval_q;
      lval_d <= lval_q;
    end
  end

  assign fval_rise = fval_q && !fval_d;
  assign fval_fall = !fval_q && fval_d;
  assign lval_fall = !lval_q && lval_d;
  assign gate_open = gate || (fval_rise && cfg.capture_en);  // Opens on first frame cycle
  assign in_crop   = (col < cfg.width) && (row < cfg.height);

  // ====================
  // Counters and frame gate
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      col  <= '0;
      row  <= '0;
      gate <= 1'b0;
    end else begin
      if (lval_fall) col <= '0;
      else if (lval_q && col != '1) col <= col + 1'b1;
      if (fval_fall) row <= '0;  // Frame end wins over line end
      else if (lval_fall && row != '1) row <= row + 1'b1;
      if (fval_fall) gate <= 1'b0;
      else if (fval_rise && cfg.capture_en) gate <= 1'b1;
    end
  end

  // ====================
  // Stage output
  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      raw.valid     <= 1'b0;
      raw.frame_end <= 1'b0;
    end else begin
      raw.valid     <= fval_q && lval_q && gate_open && in_crop;
      raw.frame_end <= fval_fall && gate;  // Ungated frames are not counted
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    raw.data <= data_q;
    raw.x    <= col;
    raw.y    <= row;
  end

endmodule

`default_nettype wire

// ==== src/bayer_bin.sv ====
// Expects RGGB order with red at column 0 row 0; odd crop edges drop the unpaired column or row
`default_nettype none
`timescale 1ns/1ps

module bayer_bin import cam_pkg::*; #(
  parameter int max_width = 1280  // Line buffer entries
) (
  input  logic  ccd_pixel_clk,
  input  logic  rst,
  pix_if.sink   raw,
  pix_if.source rgb
);

  localparam int idx_w = $clog2(max_width);

  logic [pix_w-1:0] line_buf [max_width];  // Even row samples, R and G alternating
  logic [pix_w-1:0] g_bot;                 // Green of the odd row, even column
  logic [idx_w-1:0] cur_idx;
  logic [idx_w-1:0] red_idx;
  logic [pix_w-1:0] red;
  logic [pix_w-1:0] g_top;
  logic [pix_w:0]   g_sum;                 // One spare bit before halving
  logic             odd_row;
  logic             odd_site;              // Blue sample closes a 2x2 block

  assign odd_row  = raw.y[0];
  assign odd_site = raw.valid && odd_row && raw.x[0];
  assign cur_idx  = raw.x[idx_w-1:0];
  assign red_idx  = {cur_idx[idx_w-1:1], 1'b0};

  // Block neighbours
  assign red   = line_buf[red_idx];
  assign g_top = line_buf[cur_idx];
  assign g_sum = {1'b0, g_top} + {1'b0, g_bot};

  // ====================
  // Line buffer and green hold
  always_ff @(posedge ccd_pixel_clk) begin
    if (raw.valid && !odd_row) line_buf[cur_idx] <= raw.data;
    if (raw.valid && odd_row && !raw.x[0]) g_bot <= raw.data;
  end

  // ====================
  // Binned pixel
  always_ff @(posedge ccd_pixel_clk) begin
    if (odd_site) begin
      rgb.data <= {red, g_sum[pix_w:1], raw.data};  // Truncated green mean
      rgb.x    <= raw.x >> 1;
      rgb.y    <= raw.y >> 1;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      rgb.valid     <= 1'b0;
      rgb.frame_end <= 1'b0;
    end else begin
      rgb.valid     <= odd_site;
      rgb.frame_end <= raw.frame_end;  // Kept in step with the pixels
    end
  end

endmodule

`default_nettype wire

// ==== src/pixel_format.sv ====
// Mode and threshold act on the next beat so a change mid frame splits that frame's format
`default_nettype none
`timescale 1ns/1ps

module pixel_format import cam_pkg::*; (
  input  logic      ccd_pixel_clk,
  input  logic      rst,
  cam_cfg_if.format cfg,
  pix_if.sink       rgb,
  pix_if.source     fmt
);

  logic [pix_w-1:0] red;
  logic [pix_w-1:0] green;
  logic [pix_w-1:0] blue;
  logic [out_w-1:0] word;

  assign red   = rgb.data[3*pix_w-1 -: pix_w];
  assign green = rgb.data[2*pix_w-1 -: pix_w];
  assign blue  = rgb.data[pix_w-1:0];

  always_comb begin
    case (cfg.mode)
      mode_binary: word = {out_w{green >= cfg.threshold}};  // All ones or all zeros
      default:     word = {1'b0, red[pix_w-1 -: 5], green[pix_w-1 -: 5], blue[pix_w-1 -: 5]};
    endcase
  end

  // ====================
  // Output register
  always_ff @(posedge ccd_pixel_clk) begin
    fmt.data <= word;
    fmt.x    <= rgb.x;
    fmt.y    <= rgb.y;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      fmt.valid     <= 1'b0;
      fmt.frame_end <= 1'b0;
    end else begin
      fmt.valid     <= rgb.valid;
      fmt.frame_end <= rgb.frame_end;
    end
  end

endmodule

`default_nettype wire

// ==== src/cam_pipe_top.sv ====
// Single clock domain; sensor pins must already be synchronous to ccd_pixel_clk
`default_nettype none
`timescale 1ns/1ps

module cam_pipe_top import cam_pkg::*; #(
  parameter int max_width = 1280  // Widest crop the line buffer holds
) (
  input  logic                    ccd_pixel_clk,
  input  logic                    rst,
  // Sensor
  input  logic [pix_w-1:0]        ccd_data,
  input  logic                    ccd_fval,
  input  logic                    ccd_lval,
  // AXI4-Lite slave
  input  logic [axi_addr_w-1:0]   awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [axi_data_w-1:0]   wdata,
  input  logic [axi_data_w/8-1:0] wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [axi_addr_w-1:0]   araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [axi_data_w-1:0]   rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  // Pixel output
  output logic                    out_valid,
  output logic [out_w-1:0]        out_data,
  output logic [coord_w-1:0]      out_x,
  output logic [coord_w-1:0]      out_y
);

  // ====================
  // Stage links
  cam_cfg_if                  cfg_if ();
  pix_if #(.data_w(pix_w))    raw_if ();  // Cropped raw samples
  pix_if #(.data_w(3*pix_w))  rgb_if ();  // Red, green, blue
  pix_if #(.data_w(out_w))    fmt_if ();  // Packed words

  camera_ctrl #(.max_width(max_width)) camera_ctrl_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wvalid        (wvalid),
    .wready        (wready),
    .bresp         (bresp),
    .bvalid        (bvalid),
    .bready        (bready),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rdata         (rdata),
    .rresp         (rresp),
    .rvalid        (rvalid),
    .rready        (rready),
    .cfg           (cfg_if.ctrl),
    .mon           (raw_if.monitor)  // Frame end from capture
  );

  ccd_capture ccd_capture_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .ccd_data      (ccd_data),
    .ccd_fval      (ccd_fval),
    .ccd_lval      (ccd_lval),
    .cfg           (cfg_if.capture),
    .raw           (raw_if.source)
  );

  bayer_bin #(.max_width(max_width)) bayer_bin_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .raw           (raw_if.sink),
    .rgb           (rgb_if.source)
  );

  pixel_format pixel_format_i (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .cfg           (cfg_if.format),
    .rgb           (rgb_if.sink),
    .fmt           (fmt_if.source)
  );

  // Registered in pixel_format
  assign out_valid = fmt_if.valid;
  assign out_data  = fmt_if.data;
  assign out_x     = fmt_if.x;
  assign out_y     = fmt_if.y;

endmodule

`default_nettype wire

// ==== test/cam_pipe_assert.sv ====
// Bound into cam_pipe_top; checks AXI response hold and a quiet output after reset only
`default_nettype none
`timescale 1ns/1ps

module cam_pipe_assert (
  input logic ccd_pixel_clk,
  input logic rst,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic out_valid
);

  // ====================
  // AXI response channels
  property bvalid_hold_p;
    @(posedge ccd_pixel_clk) disable iff (rst) (bvalid && !bready) |=> bvalid;
  endproperty

  property rvalid_hold_p;
    @(posedge ccd_pixel_clk) disable iff (rst) (rvalid && !rready) |=> rvalid;
  endproperty

  // Pipeline empty right after reset
  property quiet_after_reset_p;
    @(posedge ccd_pixel_clk) $fell(rst) |->
      !out_valid ##1 !out_valid ##1 !out_valid ##1 !out_valid;
  endproperty

  bvalid_hold_a: assert property (bvalid_hold_p) else $error("bvalid dropped before bready");
  rvalid_hold_a: assert property (rvalid_hold_p) else $error("rvalid dropped before rready");
  quiet_a: assert property (quiet_after_reset_p) else $error("out_valid high just after reset");

endmodule

bind cam_pipe_top cam_pipe_assert cam_pipe_assert_i (
  .ccd_pixel_clk (ccd_pixel_clk),
  .rst           (rst),
  .bvalid        (bvalid),
  .bready        (bready),
  .rvalid        (rvalid),
  .rready        (rready),
  .out_valid     (out_valid)
);

`default_nettype wire

// ==== test/tb_cam_pipe.sv ====
// Sensor frames up to 16x16 samples; stops at the first mismatch; needs --assert for the checks
`default_nettype none
`timescale 1ns/1ps

module tb_cam_pipe import cam_pkg::*; ();

  localparam int max_width  = 1280;
  localparam int drive_dly  = 2;   // ns after the rising edge
  localparam int line_gap   = 3;   // lval low between lines
  localparam int frame_gap  = 6;   // fval low between frames
  localparam int hs_limit   = 32;  // Cycles allowed per handshake
  localparam int resp_stall = 2;   // Cycles bready and rready stay low after valid
  localparam int n_cases    = 6;

  typedef struct packed {
    int        crop_w;
    int        crop_h;
    int        sens_w;
    int        sens_h;
    out_mode_e mode;
    int        thresh;
    logic      start;
  } case_t;

  typedef struct packed {
    logic [out_w-1:0]   data;
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    int unsigned        cyc;   // Cycle the beat is due
  } exp_t;

  // ====================
  // Stimulus table
  case_t cases [n_cases] = '{
    '{8, 6, 8, 6, mode_rgb555, 2048, 1'b1},     // Full frame colour
    '{6, 4, 10, 8, mode_rgb555, 2048, 1'b1},    // Crop inside sensor
    '{8, 4, 8, 4, mode_binary, 1500, 1'b1},     // Mask
    '{7, 5, 8, 6, mode_binary, 3000, 1'b1},     // Odd crop edges
    '{8, 4, 8, 4, mode_rgb555, 2048, 1'b0},     // Start clear
    '{2000, 4, 12, 4, mode_rgb555, 100, 1'b1}   // Width clamps
  };

  logic                    ccd_pixel_clk;
  logic                    rst;
  logic [pix_w-1:0]        ccd_data;
  logic                    ccd_fval;
  logic                    ccd_lval;
  logic [axi_addr_w-1:0]   awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [axi_data_w-1:0]   wdata;
  logic [axi_data_w/8-1:0] wstrb;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [axi_addr_w-1:0]   araddr;
  logic                    arvalid;
  logic                    arready;
  logic [axi_data_w-1:0]   rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready;
  logic                    out_valid;
  logic [out_w-1:0]        out_data;
  logic [coord_w-1:0]      out_x;
  logic [coord_w-1:0]      out_y;

  logic [pix_w-1:0] frame_buf [16][16];  // Samples of the frame being sent
  exp_t             exp_q [$];
  logic [31:0]      lcg_state = 32'h81ad;
  int unsigned      cyc = 0;
  int               frames_exp = 0;     // Gated frames so far
  bit               ended = 1'b0;

  cam_pipe_top #(.max_width(max_width)) cam_pipe_top_i (.*);

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #10 ccd_pixel_clk = ~ccd_pixel_clk;  // 20 ns
  end

  always @(posedge ccd_pixel_clk) cyc <= cyc + 1;

  // ====================
  // Helpers
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Output word from the format rules
  function automatic logic [out_w-1:0] expect_word(input logic [pix_w-1:0] red, green, blue,
                                                  input out_mode_e m, input int th);
    int drop;  // Low bits lost from each colour
    drop = pix_w - 5;
    if (m == mode_binary) return (int'(green) >= th) ? 16'hFFFF : 16'h0000;
    return out_w'((int'(red) >> drop) * 1024 + (int'(green) >> drop) * 32
                  + (int'(blue) >> drop));
  endfunction

  task automatic report_mismatch(input string msg);
    ended = 1'b1;
    $display("** Error @ %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abort_run(input string msg);
    ended = 1'b1;
    $display("Run aborted: %s", msg);
    $display("Checks failed");
    $fatal(1, "stopped");
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge ccd_pixel_clk);
      #drive_dly;
    end
  endtask

  // ====================
  // AXI4-Lite master, called at drive time
  task automatic axi_write(input logic [axi_addr_w-1:0] addr, input logic [axi_data_w-1:0] data,
                           output logic [1:0] resp);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;  // Response is held back for a while
    n = 0;
    @(negedge ccd_pixel_clk);
    while (!(awready && wready)) begin
      n++;
      if (n > hs_limit) abort_run("write address and data were never accepted");
      @(negedge ccd_pixel_clk);
    end
    @(posedge ccd_pixel_clk);
    #drive_dly;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    @(negedge ccd_pixel_clk);
    while (!bvalid) begin  // Rises one cycle after accept
      n++;
      if (n > hs_limit) abort_run("write response never arrived");
      @(negedge ccd_pixel_clk);
    end
    resp = bresp;
    idle_cycles(resp_stall);  // bvalid has to hold meanwhile
    bready = 1'b1;
    @(posedge ccd_pixel_clk);
    #drive_dly;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [axi_addr_w-1:0] addr, output logic [axi_data_w-1:0] data,
                          output logic [1:0] resp);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;  // Read data is held back for a while
    n = 0;
    @(negedge ccd_pixel_clk);
    while (!arready) begin
      n++;
      if (n > hs_limit) abort_run("read address was never accepted");
      @(negedge ccd_pixel_clk);
    end
    @(posedge ccd_pixel_clk);
    #drive_dly;
    arvalid = 1'b0;
    n = 0;
    @(negedge ccd_pixel_clk);
    while (!rvalid) begin
      n++;
      if (n > hs_limit) abort_run("read data never arrived");
      @(negedge ccd_pixel_clk);
    end
    data = rdata;
    resp = rresp;
    idle_cycles(resp_stall);  // rvalid has to hold meanwhile
    rready = 1'b1;
    @(posedge ccd_pixel_clk);
    #drive_dly;
    rready = 1'b0;
  endtask

  task automatic write_check(input logic [axi_addr_w-1:0] addr, input logic [axi_data_w-1:0] data,
                             input logic [1:0] exp_resp);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    assert (resp == exp_resp) else
      report_mismatch($sformatf("write 0x%02h bresp %0d, expected %0d", addr, resp, exp_resp));
  endtask

  task automatic read_check(input logic [axi_addr_w-1:0] addr, input logic [axi_data_w-1:0] exp_data,
                            input logic [1:0] exp_resp);
    logic [axi_data_w-1:0] data;
    logic [1:0]            resp;
    axi_read(addr, data, resp);
    assert (resp == exp_resp) else
      report_mismatch($sformatf("read 0x%02h rresp %0d, expected %0d", addr, resp, exp_resp));
    assert (data == exp_data) else
      report_mismatch($sformatf("read 0x%02h data %0d, expected %0d", addr, data, exp_data));
  endtask

  // Program one table row and read it all back
  task automatic apply_regs(input case_t t);
    logic [axi_data_w-1:0] ctrl_val;
    int                    w_exp;
    ctrl_val = {30'd0, t.mode, t.start};
    w_exp    = (t.crop_w > max_width) ? max_width : t.crop_w;  // Clamp
    write_check(reg_width, t.crop_w, resp_okay);
    write_check(reg_height, t.crop_h, resp_okay);
    write_check(reg_thresh, t.thresh, resp_okay);
    write_check(reg_ctrl, ctrl_val, resp_okay);
    read_check(reg_width, w_exp, resp_okay);
    read_check(reg_height, t.crop_h, resp_okay);
    read_check(reg_thresh, t.thresh, resp_okay);
    read_check(reg_ctrl, ctrl_val, resp_okay);
  endtask

  // ====================
  // Sensor model with reference binning
  task automatic stream_frame(input case_t t, input bit gated);
    logic [pix_w-1:0] s;
    int               gmean;  // Truncated mean of the two greens
    exp_t             e;
    int               cw;
    cw = (t.crop_w > max_width) ? max_width : t.crop_w;
    ccd_fval = 1'b1;
    idle_cycles(2);  // Front porch
    for (int r = 0; r < t.sens_h; r++) begin
      for (int c = 0; c < t.sens_w; c++) begin
        lcg_state       = lcg_step(lcg_state);
        s               = lcg_state[27:16];
        frame_buf[r][c] = s;
        ccd_lval        = 1'b1;
        ccd_data        = s;
        // Blue site closes a 2x2 block inside the crop
        if (gated && r[0] && c[0] && r < t.crop_h && c < cw) begin
          gmean  = (int'(frame_buf[r-1][c]) + int'(frame_buf[r][c-1])) / 2;
          e.data = expect_word(frame_buf[r-1][c-1], pix_w'(gmean), s, t.mode, t.thresh);
          e.x    = coord_w'(c >> 1);
          e.y    = coord_w'(r >> 1);
          e.cyc  = cyc + 4;  // Fixed pipeline latency
          exp_q.push_back(e);
        end
        idle_cycles(1);
      end
      ccd_lval = 1'b0;
      idle_cycles(line_gap);
    end
    idle_cycles(2);
    ccd_fval = 1'b0;
    idle_cycles(frame_gap);
    if (gated) frames_exp++;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      n++;
      if (n > hs_limit) abort_run("expected pixels never came out");
      idle_cycles(1);
    end
  endtask

  // ====================
  // Output monitor
  always @(negedge ccd_pixel_clk) begin
    exp_t e;
    if (!rst && out_valid) begin
      assert (exp_q.size() > 0) else
        report_mismatch($sformatf("unexpected beat at (%0d,%0d)", out_x, out_y));
      e = exp_q.pop_front();
      assert (out_data == e.data) else
        report_mismatch($sformatf("data %h, expected %h at (%0d,%0d)", out_data, e.data, e.x, e.y));
      assert (out_x == e.x && out_y == e.y) else
        report_mismatch($sformatf("at (%0d,%0d), expected (%0d,%0d)", out_x, out_y, e.x, e.y));
      assert (cyc == e.cyc) else
        report_mismatch($sformatf("beat in cycle %0d, expected %0d", cyc, e.cyc));
    end
  end

  // Watchdog budget from the table
  initial begin
    int budget;
    budget = 2000;
    for (int i = 0; i < n_cases; i++) begin
      budget += 2 * (cases[i].sens_h * (cases[i].sens_w + line_gap) + frame_gap) + 300;
    end
    budget += 4 * (cases[0].sens_h * (cases[0].sens_w + line_gap) + frame_gap);
    repeat (budget) @(posedge ccd_pixel_clk);
    abort_run("watchdog expired before the tests finished");
  end

  final begin
    if (!ended) $display("Checks failed");  // Run stopped by a bound assertion
  end

  // ====================
  // Main sequence
  initial begin
    case_t t;
    rst      = 1'b1;
    ccd_data = '0;
    ccd_fval = 1'b0;
    ccd_lval = 1'b0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    repeat (10) @(posedge ccd_pixel_clk);
    #drive_dly;
    rst = 1'b0;
    idle_cycles(2);

    // Reset values and bus errors
    read_check(reg_ctrl, 0, resp_okay);
    read_check(reg_width, 1280, resp_okay);
    write_check(5'h14, 32'h1234, resp_slverr);  // Unmapped
    read_check(5'h14, 0, resp_slverr);
    write_check(reg_frames, 32'h5, resp_slverr);  // Read only
    read_check(reg_frames, 0, resp_okay);

    for (int i = 0; i < n_cases; i++) begin
      apply_regs(cases[i]);
      stream_frame(cases[i], cases[i].start);
      wait_drain();
      read_check(reg_frames, frames_exp, resp_okay);
    end

    // Start set in mid frame, output only from the next one
    t       = cases[0];
    t.start = 1'b0;
    apply_regs(t);
    fork
      stream_frame(t, 1'b0);
      begin
        idle_cycles(12);  // Inside the first line
        write_check(reg_ctrl, 32'h1, resp_okay);
      end
    join
    stream_frame(t, 1'b1);
    wait_drain();
    read_check(reg_frames, frames_exp, resp_okay);

    ended = 1'b1;
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
src/cam_pkg.sv
src/cam_ifs.sv
src/camera_ctrl.sv
src/ccd_capture.sv
src/bayer_bin.sv
src/pixel_format.sv
src/cam_pipe_top.sv
test/cam_pipe_assert.sv
test/tb_cam_pipe.sv

// ==== Makefile ====
# Verilator build and run of the camera pixel path testbench

VERILATOR ?= verilator
TOP       ?= tb_cam_pipe
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check

# Pass only if the pass line is in the log
check:
	@grep -qxF "$(PASS_MSG)" $(LOG) && echo "Simulation PASSED" || \
	  (echo "Simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
